/* hw/cache_pkg.sv */
package cache_pkg;

  // address split: tag | index | block offset | byte offset
  localparam int WORD_W = 32;
  localparam int TAG_W  = 26;
  localparam int IDX_W  = 3;

  localparam int SETS = 8;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [IDX_W-1:0]  idx_t;

  typedef enum logic [3:0] {
    IDLE,
    // miss handling, victim first then fill
    WB0,
    WB1,
    FILL0,
    FILL1,
    // halt flush
    FLUSH_SCAN,
    FLUSH_WB0,
    FLUSH_WB1,
    FLUSHED
  } dcache_state_t;

endpackage

/* hw/datapath_cache_if.sv */
`timescale 1ns/1ps

interface datapath_cache_if
  import cache_pkg::*;
();

  // request side, levels held until dhit
  logic  dmemREN;
  logic  dmemWEN;
  word_t dmemaddr;
  word_t dmemstore;
  logic  halt;

  // response side
  logic  dhit;
  word_t dmemload;
  logic  flushed;

  modport dcache (
    input  dmemREN, dmemWEN, dmemaddr, dmemstore, halt,
    output dhit, dmemload, flushed
  );

  modport dp (
    output dmemREN, dmemWEN, dmemaddr, dmemstore, halt,
    input  dhit, dmemload, flushed
  );

endinterface

/* hw/caches_if.sv */
`timescale 1ns/1ps

interface caches_if
  import cache_pkg::*;
();

  logic  dREN;
  logic  dWEN;
  word_t daddr;
  word_t dstore;
  // dload valid only in the cycle dwait is low
  word_t dload;
  logic  dwait;

  modport dcache (
    output dREN, dWEN, daddr, dstore,
    input  dload, dwait
  );

  modport mem (
    input  dREN, dWEN, daddr, dstore,
    output dload, dwait
  );

endinterface

/* hw/dcache.sv */
`timescale 1ns/1ps

module dcache
  import cache_pkg::*;
(
  input logic CLK,
  input logic nRST,
  datapath_cache_if.dcache dcif,
  caches_if.dcache cdif
);

  // storage, indexed [way][set] and [way][set][word]
  tag_t  tags [2][SETS];
  word_t data [2][SETS][2];
  logic [1:0][SETS-1:0] valid;
  logic [1:0][SETS-1:0] dirty;
  // lru bit names the way to replace next
  logic [SETS-1:0] lru;

  dcache_state_t state;
  dcache_state_t next_state;
  idx_t set_cnt;

  tag_t req_tag;
  idx_t req_idx;
  logic req_off;
  logic req;

  logic [1:0] hit_way;
  logic hit;
  logic hit_sel;
  logic hit_ok;
  logic store_hit;
  logic victim;

  logic in_flush;
  logic flush_way;
  logic set_dirty;
  logic more_dirty;
  logic flush_last;
  logic set_next;

  logic mem_way;
  idx_t mem_idx;
  logic mem_off;
  logic mem_done;
  logic fill_ok;
  logic fill_end;
  word_t wb_addr;
  word_t fill_addr;

  assign req_tag = dcif.dmemaddr[31:6];
  assign req_idx = dcif.dmemaddr[5:3];
  assign req_off = dcif.dmemaddr[2];
  assign req     = dcif.dmemREN | dcif.dmemWEN;

  // tag compare on both ways
  assign hit_way[0] = valid[0][req_idx] && (tags[0][req_idx] == req_tag);
  assign hit_way[1] = valid[1][req_idx] && (tags[1][req_idx] == req_tag);
  assign hit        = |hit_way;
  assign hit_sel    = hit_way[1];
  assign victim     = lru[req_idx];

  assign hit_ok    = (state == IDLE) && !dcif.halt && req && hit;
  assign store_hit = hit_ok && dcif.dmemWEN;

  // flush bookkeeping for the set under the counter
  assign in_flush   = state inside {FLUSH_SCAN, FLUSH_WB0, FLUSH_WB1};
  assign set_dirty  = dirty[0][set_cnt] | dirty[1][set_cnt];
  assign flush_way  = ~dirty[0][set_cnt];
  assign more_dirty = !flush_way && dirty[1][set_cnt];
  assign flush_last = (set_cnt == idx_t'(SETS - 1));
  assign set_next   = ((state == FLUSH_SCAN) && !set_dirty) ||
                      ((state == FLUSH_WB1) && mem_done && !more_dirty);

  // memory side addressing, shared by miss and flush paths
  assign mem_way   = in_flush ? flush_way : victim;
  assign mem_idx   = in_flush ? set_cnt : req_idx;
  assign mem_off   = state inside {WB1, FILL1, FLUSH_WB1};
  assign mem_done  = !cdif.dwait;
  assign wb_addr   = {tags[mem_way][mem_idx], mem_idx, mem_off, 2'b00};
  assign fill_addr = {req_tag, req_idx, mem_off, 2'b00};
  assign fill_ok   = cdif.dREN && mem_done;
  assign fill_end  = (state == FILL1) && mem_done;

  assign cdif.dREN   = state inside {FILL0, FILL1};
  assign cdif.dWEN   = state inside {WB0, WB1, FLUSH_WB0, FLUSH_WB1};
  assign cdif.daddr  = cdif.dREN ? fill_addr : wb_addr;
  assign cdif.dstore = data[mem_way][mem_idx][mem_off];

  assign dcif.dhit     = hit_ok;
  assign dcif.dmemload = hit_ok ? data[hit_sel][req_idx][req_off] : '0;
  assign dcif.flushed  = (state == FLUSHED) && dcif.halt;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (dcif.halt) begin
          next_state = FLUSH_SCAN;
        end else if (req && !hit) begin
          next_state = dirty[victim][req_idx] ? WB0 : FILL0;
        end
      end
      WB0: begin
        if (mem_done) begin
          next_state = WB1;
        end
      end
      WB1: begin
        if (mem_done) begin
          next_state = FILL0;
        end
      end
      FILL0: begin
        if (mem_done) begin
          next_state = FILL1;
        end
      end
      FILL1: begin
        // back to IDLE, where the access now hits
        if (mem_done) begin
          next_state = IDLE;
        end
      end
      FLUSH_SCAN: begin
        if (set_dirty) begin
          next_state = FLUSH_WB0;
        end else if (flush_last) begin
          next_state = FLUSHED;
        end
      end
      FLUSH_WB0: begin
        if (mem_done) begin
          next_state = FLUSH_WB1;
        end
      end
      FLUSH_WB1: begin
        if (mem_done) begin
          if (more_dirty) begin
            next_state = FLUSH_WB0;
          end else if (flush_last) begin
            next_state = FLUSHED;
          end else begin
            next_state = FLUSH_SCAN;
          end
        end
      end
      FLUSHED: begin
        if (!dcif.halt) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state   <= IDLE;
      set_cnt <= '0;
      valid   <= '0;
      dirty   <= '0;
      lru     <= '0;
    end else begin
      state <= next_state;
      // flush always starts from set 0
      if (state == IDLE) begin
        set_cnt <= '0;
      end
      if (hit_ok) begin
        lru[req_idx] <= ~hit_sel;
        if (dcif.dmemWEN) begin
          dirty[hit_sel][req_idx] <= 1'b1;
        end
      end
      if (fill_end) begin
        valid[victim][req_idx] <= 1'b1;
        dirty[victim][req_idx] <= 1'b0;
      end
      if ((state == FLUSH_WB1) && mem_done) begin
        dirty[flush_way][set_cnt] <= 1'b0;
      end
      if (set_next) begin
        if (flush_last) begin
          valid <= '0;
          dirty <= '0;
        end else begin
          set_cnt <= set_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (store_hit) begin
      data[hit_sel][req_idx][req_off] <= dcif.dmemstore;
    end
    if (fill_ok) begin
      data[victim][req_idx][mem_off] <= cdif.dload;
    end
    // tag goes in with the second word
    if (fill_end) begin
      tags[victim][req_idx] <= req_tag;
    end
  end

endmodule

/* hw/wait_ram.sv */
`timescale 1ns/1ps

module wait_ram
  import cache_pkg::*;
#(
  parameter int WAIT_CYCLES = 2,
  parameter int MEM_WORDS   = 1024
) (
  input logic CLK,
  input logic nRST,
  caches_if.mem mif
);

  localparam int AW    = $clog2(MEM_WORDS);
  localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  word_t mem [MEM_WORDS];
  logic [AW-1:0] word_idx;
  logic [CNT_W-1:0] wait_cnt;
  logic req;
  logic done;

  assign req      = mif.dREN | mif.dWEN;
  assign word_idx = mif.daddr[AW+1:2];

  // wait until the counter reaches WAIT_CYCLES
  assign mif.dwait = req && (wait_cnt < CNT_W'(WAIT_CYCLES));
  assign done      = req && !mif.dwait;
  assign mif.dload = mif.dREN ? mem[word_idx] : '0;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (!req || done) begin
      // next access counts from zero again
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (done && mif.dWEN) begin
      mem[word_idx] <= mif.dstore;
    end
  end

endmodule

/* hw/cache_top.sv */
`timescale 1ns/1ps

module cache_top
  import cache_pkg::*;
#(
  parameter int WAIT_CYCLES = 2,
  parameter int MEM_WORDS   = 1024
) (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  dmemREN,
  input  logic  dmemWEN,
  input  word_t dmemaddr,
  input  word_t dmemstore,
  input  logic  halt,
  output logic  dhit,
  output word_t dmemload,
  output logic  flushed
);

  datapath_cache_if dcif ();
  caches_if cif ();

  // datapath ports onto the interface
  assign dcif.dmemREN   = dmemREN;
  assign dcif.dmemWEN   = dmemWEN;
  assign dcif.dmemaddr  = dmemaddr;
  assign dcif.dmemstore = dmemstore;
  assign dcif.halt      = halt;

  assign dhit     = dcif.dhit;
  assign dmemload = dcif.dmemload;
  assign flushed  = dcif.flushed;

  dcache dcache0 (
    .CLK  (CLK),
    .nRST (nRST),
    .dcif (dcif),
    .cdif (cif)
  );

  wait_ram #(
    .WAIT_CYCLES (WAIT_CYCLES),
    .MEM_WORDS   (MEM_WORDS)
  ) ram0 (
    .CLK  (CLK),
    .nRST (nRST),
    .mif  (cif)
  );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_NS = 5
) (
  output logic CLK
);

  // 10 ns period
  initial begin
    CLK = 1'b0;
    forever #(HALF_NS) CLK = ~CLK;
  end

endmodule

/* bench/cache_asserts.sv */
`timescale 1ns/1ps

module cache_asserts
  import cache_pkg::*;
(
  input logic          CLK,
  input logic          nRST,
  input logic          dmemREN,
  input logic          dmemWEN,
  input logic          halt,
  input logic          dhit,
  input logic          flushed,
  input logic          mem_ren,
  input logic          mem_wen,
  input dcache_state_t state
);

  int fail_count = 0;

  mem_one_op: assert property (@(posedge CLK) disable iff (!nRST)
    !(mem_ren && mem_wen))
    else begin
      $error("dREN and dWEN high together");
      fail_count++;
    end

  hit_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
    dhit |-> (dmemREN || dmemWEN))
    else begin
      $error("dhit high with no request");
      fail_count++;
    end

  flushed_needs_halt: assert property (@(posedge CLK) disable iff (!nRST)
    flushed |-> halt)
    else begin
      $error("flushed high while halt is low");
      fail_count++;
    end

  // writes only come from write-back or flush states
  write_not_idle: assert property (@(posedge CLK) disable iff (!nRST)
    mem_wen |-> (state != IDLE))
    else begin
      $error("memory write issued in IDLE");
      fail_count++;
    end

  // one edge on, so the first edge after release is covered too
  reset_quiet: assert property (@(posedge CLK)
    !nRST |=> (!dhit && !flushed && !mem_ren && !mem_wen && (state == IDLE)))
    else begin
      $error("control outputs not low after reset");
      fail_count++;
    end

endmodule

bind cache_top cache_asserts asserts0 (
  .CLK     (CLK),
  .nRST    (nRST),
  .dmemREN (dmemREN),
  .dmemWEN (dmemWEN),
  .halt    (halt),
  .dhit    (dhit),
  .flushed (flushed),
  .mem_ren (cif.dREN),
  .mem_wen (cif.dWEN),
  .state   (dcache0.state)
);

/* bench/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb
  import cache_pkg::*;
();

  // stores+loads per phase, last term is the readback bound
  localparam int N_ACCESS = 32 + 14 + 7 + 16 + 41;
  localparam int N_FLUSH  = 1;
  localparam int LIMIT    = 40 * N_ACCESS + 400 * N_FLUSH + 20;

  logic  CLK;
  logic  nRST;
  logic  dmemREN;
  logic  dmemWEN;
  logic  halt;
  logic  dhit;
  logic  flushed;
  word_t dmemaddr;
  word_t dmemstore;
  word_t dmemload;

  word_t model [word_t];
  tag_t  tags [8];

  tb_clock clk0 (.CLK(CLK));

  cache_top #(.WAIT_CYCLES(2)) dut0 (.*);

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1);
  endtask

  // addresses stay below 4 KB so the RAM does not alias
  function automatic word_t addr_of(input tag_t tag, input idx_t idx, input logic off);
    return {tag, idx, off, 2'b00};
  endfunction

  task automatic pick_tags();
    bit used [64];
    int t;
    foreach (tags[i]) begin
      do begin
        t = $urandom_range(63);
      end while (used[t]);
      used[t] = 1'b1;
      tags[i] = tag_t'(t);
    end
  endtask

  // dhit sampled mid-cycle
  task automatic wait_hit();
    do begin
      @(negedge CLK);
    end while (!dhit);
  endtask

  task automatic store_word(input word_t addr, input word_t value);
    dmemWEN   = 1'b1;
    dmemaddr  = addr;
    dmemstore = value;
    wait_hit();
    model[addr] = value;
    @(posedge CLK);
    #1;
    dmemWEN = 1'b0;
  endtask

  task automatic load_word(input word_t addr, input bit fast);
    word_t want;
    want     = model[addr];
    dmemREN  = 1'b1;
    dmemaddr = addr;
    if (fast) begin
      @(negedge CLK);
      assert (dhit)
        else stop_run($sformatf("FAIL dhit at %h expected %h got %h", addr, 1'b1, dhit));
    end else begin
      wait_hit();
    end
    assert (dmemload === want)
      else stop_run($sformatf("FAIL dmemload at %h expected %h got %h", addr, want, dmemload));
    @(posedge CLK);
    #1;
    dmemREN = 1'b0;
  endtask

  always @(posedge CLK) begin
    if (dut0.asserts0.fail_count != 0) begin
      stop_run("a bound assertion failed");
    end
  end

  initial begin
    repeat (LIMIT) @(posedge CLK);
    stop_run($sformatf("run timed out after %0d cycles", LIMIT));
  end

  initial begin
    void'($urandom(96038));
    nRST      = 1'b0;
    dmemREN   = 1'b0;
    dmemWEN   = 1'b0;
    halt      = 1'b0;
    dmemaddr  = '0;
    dmemstore = '0;
    pick_tags();
    repeat (5) @(posedge CLK);
    #1;
    nRST = 1'b1;

    // every set and both words, then read back as hits
    for (int s = 0; s < SETS; s++) begin
      for (int o = 0; o < 2; o++) begin
        store_word(addr_of(tags[0], idx_t'(s), o[0]), $urandom);
      end
    end
    for (int s = 0; s < SETS; s++) begin
      for (int o = 0; o < 2; o++) begin
        load_word(addr_of(tags[0], idx_t'(s), o[0]), 1'b1);
      end
    end

    // four tags through set 5, dirty victims come back from memory
    for (int t = 1; t <= 3; t++) begin
      store_word(addr_of(tags[t], 3'd5, 1'b0), $urandom);
      store_word(addr_of(tags[t], 3'd5, 1'b1), $urandom);
    end
    for (int t = 0; t <= 3; t++) begin
      load_word(addr_of(tags[t], 3'd5, 1'b0), 1'b0);
      load_word(addr_of(tags[t], 3'd5, 1'b1), 1'b0);
    end

    // lru: touch A, miss on C, A must still hit
    store_word(addr_of(tags[4], 3'd2, 1'b0), $urandom);
    store_word(addr_of(tags[5], 3'd2, 1'b0), $urandom);
    load_word(addr_of(tags[4], 3'd2, 1'b0), 1'b1);
    store_word(addr_of(tags[6], 3'd2, 1'b1), $urandom);
    load_word(addr_of(tags[4], 3'd2, 1'b0), 1'b1);
    load_word(addr_of(tags[5], 3'd2, 1'b0), 1'b0);
    load_word(addr_of(tags[6], 3'd2, 1'b1), 1'b0);

    // flush after dirtying all sets
    for (int s = 0; s < SETS; s++) begin
      for (int o = 0; o < 2; o++) begin
        store_word(addr_of(tags[7], idx_t'(s), o[0]), $urandom);
      end
    end
    halt = 1'b1;
    do begin
      @(negedge CLK);
    end while (!flushed);
    @(posedge CLK);
    #1;
    halt = 1'b0;
    foreach (model[a]) begin
      load_word(a, 1'b0);
    end

    if (dut0.asserts0.fail_count == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      stop_run("a bound assertion failed");
    end
  end

endmodule

/* compile.f */
hw/cache_pkg.sv
hw/datapath_cache_if.sv
hw/caches_if.sv
hw/dcache.sv
hw/wait_ram.sv
hw/cache_top.sv
bench/tb_clock.sv
bench/cache_asserts.sv
bench/cache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - hw/cache_pkg.sv
  - hw/datapath_cache_if.sv
  - hw/caches_if.sv
  - hw/dcache.sv
  - hw/wait_ram.sv
  - hw/cache_top.sv
  - target: simulation
    files:
      - bench/tb_clock.sv
      - bench/cache_asserts.sv
      - bench/cache_tb.sv
